// File: source/atom_kbd_cfg.svh
// Keyboard matrix geometry, joystick bit positions and modifier scancodes
`ifndef ATOM_KBD_CFG_SVH
`define ATOM_KBD_CFG_SVH

// Atom matrix size
`define ATOM_ROWS 10
`define ATOM_COLS 6

// Bit positions inside a joystick word
`define JOY_RIGHT 0
`define JOY_LEFT  1
`define JOY_DOWN  2
`define JOY_UP    3
`define JOY_FIRE  4

// Turbo select keys
`define SC_F1 9'h005
`define SC_F2 9'h006
`define SC_F3 9'h004
`define SC_F4 9'h00C

// Modifier keys, bit 8 is the E0 prefix
`define SC_F10    9'h009  // Break
`define SC_LALT   9'h011  // Repeat
`define SC_LSHIFT 9'h012
`define SC_RSHIFT 9'h059
`define SC_LCTRL  9'h014
`define SC_RCTRL  9'h114

`endif

// File: source/atom_kbd_pkg.sv
// Package atom_kbd_pkg with the keyboard mapper types
`default_nettype none

`include "atom_kbd_cfg.svh"

package atom_kbd_pkg;

    // PS/2 code with the extended flag on top
    typedef logic [8:0] scancode_t;

    // Matrix row number as scanned by the host
    typedef logic [3:0] row_idx_t;

    // Column number within one row
    typedef logic [2:0] col_idx_t;

    // One row of column bits, low means key down
    typedef logic [`ATOM_COLS-1:0] key_bits_t;

    // Turbo speed from F1 to F4
    typedef logic [1:0] turbo_t;

    // Raw joystick word, only the low five bits are used
    typedef logic [15:0] joy_t;

endpackage

`default_nettype wire

// File: source/key_event_if.sv
// Interface key_event_if carrying one matrix key event per cycle
`timescale 1ns/1ps
`default_nettype none

interface key_event_if
    import atom_kbd_pkg::*;
();

    logic     valid;    // High for one cycle per event
    logic     pressed;  // 1 on make, 0 on break
    row_idx_t row;
    col_idx_t col;

    // Event source, no back-pressure
    modport decoder (
        output valid, pressed, row, col
    );

    modport matrix (
        input valid, pressed, row, col
    );

endinterface

`default_nettype wire

// File: source/scancode_decoder.sv
// Module scancode_decoder mapping PS/2 codes to Atom matrix events and modifiers
`timescale 1ns/1ps
`default_nettype none

`include "atom_kbd_cfg.svh"

module scancode_decoder
    import atom_kbd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      ps2_strobe,
    input  logic      ps2_pressed,
    input  scancode_t ps2_code,
    key_event_if.decoder ev,
    output logic      shift_out,
    output logic      ctrl_out,
    output logic      repeat_out,
    output logic      break_out,
    output turbo_t    turbo
);

    logic     map_hit;
    row_idx_t map_row;
    col_idx_t map_col;

    // Original Atom layout lookup
    always_comb begin
        map_hit = 1'b1;
        map_row = '0;
        map_col = '0;
        casez (ps2_code)
            9'h029: {map_row, map_col} = {4'd9, 3'd0};  // Space
            9'h054: {map_row, map_col} = {4'd8, 3'd0};  // [
            9'h05D: {map_row, map_col} = {4'd7, 3'd0};  // Backslash
            9'h05B: {map_row, map_col} = {4'd6, 3'd0};  // ]
            9'h00D: {map_row, map_col} = {4'd5, 3'd0};  // Up arrow on Tab
            9'h058: {map_row, map_col} = {4'd4, 3'd0};  // Lock on Caps Lock
            9'b?_0111_0100: {map_row, map_col} = {4'd3, 3'd0};  // Right
            9'b?_0111_0101: {map_row, map_col} = {4'd2, 3'd0};  // Up
            9'h05A: {map_row, map_col} = {4'd6, 3'd1};  // Return
            9'b?_0110_1001: {map_row, map_col} = {4'd5, 3'd1};  // Copy on End
            9'h066: {map_row, map_col} = {4'd4, 3'd1};  // Delete
            9'h045: {map_row, map_col} = {4'd3, 3'd1};  // 0
            9'h016: {map_row, map_col} = {4'd2, 3'd1};  // 1
            9'h01E: {map_row, map_col} = {4'd1, 3'd1};  // 2
            9'h026: {map_row, map_col} = {4'd0, 3'd1};  // 3
            9'h025: {map_row, map_col} = {4'd9, 3'd2};  // 4
            9'h02E: {map_row, map_col} = {4'd8, 3'd2};  // 5
            9'h036: {map_row, map_col} = {4'd7, 3'd2};  // 6
            9'h03D: {map_row, map_col} = {4'd6, 3'd2};  // 7
            9'h03E: {map_row, map_col} = {4'd5, 3'd2};  // 8
            9'h046: {map_row, map_col} = {4'd4, 3'd2};  // 9
            9'h052: {map_row, map_col} = {4'd3, 3'd2};  // Colon on quote key
            9'h04C: {map_row, map_col} = {4'd2, 3'd2};  // ;
            9'h041: {map_row, map_col} = {4'd1, 3'd2};  // ,
            9'h04E: {map_row, map_col} = {4'd0, 3'd2};  // -
            9'h049: {map_row, map_col} = {4'd9, 3'd3};  // .
            9'h04A: {map_row, map_col} = {4'd8, 3'd3};  // /
            9'h055: {map_row, map_col} = {4'd7, 3'd3};  // @ on = key
            9'h01C: {map_row, map_col} = {4'd6, 3'd3};  // A
            9'h032: {map_row, map_col} = {4'd5, 3'd3};  // B
            9'h021: {map_row, map_col} = {4'd4, 3'd3};  // C
            9'h023: {map_row, map_col} = {4'd3, 3'd3};  // D
            9'h024: {map_row, map_col} = {4'd2, 3'd3};  // E
            9'h02B: {map_row, map_col} = {4'd1, 3'd3};  // F
            9'h034: {map_row, map_col} = {4'd0, 3'd3};  // G
            9'h033: {map_row, map_col} = {4'd9, 3'd4};  // H
            9'h043: {map_row, map_col} = {4'd8, 3'd4};  // I
            9'h03B: {map_row, map_col} = {4'd7, 3'd4};  // J
            9'h042: {map_row, map_col} = {4'd6, 3'd4};  // K
            9'h04B: {map_row, map_col} = {4'd5, 3'd4};  // L
            9'h03A: {map_row, map_col} = {4'd4, 3'd4};  // M
            9'h031: {map_row, map_col} = {4'd3, 3'd4};  // N
            9'h044: {map_row, map_col} = {4'd2, 3'd4};  // O
            9'h04D: {map_row, map_col} = {4'd1, 3'd4};  // P
            9'h015: {map_row, map_col} = {4'd0, 3'd4};  // Q
            9'h02D: {map_row, map_col} = {4'd9, 3'd5};  // R
            9'h01B: {map_row, map_col} = {4'd8, 3'd5};  // S
            9'h02C: {map_row, map_col} = {4'd7, 3'd5};  // T
            9'h03C: {map_row, map_col} = {4'd6, 3'd5};  // U
            9'h02A: {map_row, map_col} = {4'd5, 3'd5};  // V
            9'h01D: {map_row, map_col} = {4'd4, 3'd5};  // W
            9'h022: {map_row, map_col} = {4'd3, 3'd5};  // X
            9'h035: {map_row, map_col} = {4'd2, 3'd5};  // Y
            9'h01A: {map_row, map_col} = {4'd1, 3'd5};  // Z
            9'h076: {map_row, map_col} = {4'd0, 3'd5};  // Escape
            default: map_hit = 1'b0;                    // Modifiers and unmapped keys
        endcase
    end

    // Event valid and modifier state
    always_ff @(posedge clk) begin
        if (reset) begin
            ev.valid   <= 1'b0;
            shift_out  <= 1'b1;
            ctrl_out   <= 1'b1;
            repeat_out <= 1'b1;
            break_out  <= 1'b1;
            turbo      <= 2'd0;
        end else begin
            ev.valid <= ps2_strobe & map_hit;
            if (ps2_strobe) begin
                case (ps2_code)
                    `SC_F1: turbo <= 2'd0;
                    `SC_F2: turbo <= 2'd1;
                    `SC_F3: turbo <= 2'd2;
                    `SC_F4: turbo <= 2'd3;
                    `SC_LSHIFT, `SC_RSHIFT: shift_out <= ~ps2_pressed;
                    `SC_LCTRL, `SC_RCTRL: ctrl_out <= ~ps2_pressed;
                    `SC_LALT: repeat_out <= ~ps2_pressed;
                    `SC_F10: break_out <= ~ps2_pressed;
                    default: ;
                endcase
            end
        end
    end

    // Event payload, qualified by ev.valid
    always_ff @(posedge clk) begin
        if (ps2_strobe) begin
            ev.pressed <= ps2_pressed;
            ev.row     <= map_row;
            ev.col     <= map_col;
        end
    end

endmodule

`default_nettype wire

// File: source/key_matrix.sv
// Module key_matrix holding key state with a two-stage row scan and joystick mask
`timescale 1ns/1ps
`default_nettype none

`include "atom_kbd_cfg.svh"

module key_matrix
    import atom_kbd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    key_event_if.matrix ev,
    input  row_idx_t  row,
    input  joy_t      joy1,
    input  joy_t      joy2,
    output key_bits_t keyout
);

    key_bits_t keys [`ATOM_ROWS];
    key_bits_t scan_data;  // Stage 1 row data
    row_idx_t  scan_row;   // Row number that goes with scan_data
    key_bits_t joy_mask;

    // Joystick word to column order 1, U, R, D, L, F
    function automatic key_bits_t joy_bits(input joy_t j);
        return {1'b1, j[`JOY_UP], j[`JOY_RIGHT], j[`JOY_DOWN], j[`JOY_LEFT], j[`JOY_FIRE]};
    endfunction

    // Key state, one bit per matrix position
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `ATOM_ROWS; r++) begin
                keys[r] <= '1;
            end
        end else if (ev.valid) begin
            keys[ev.row][ev.col] <= ~ev.pressed;  // Low while held
        end
    end

    // Mask follows the registered row, not the live one
    always_comb begin
        joy_mask = '1;
        if (scan_row == 4'd0)
            joy_mask = joy_bits(joy1);
        else if (scan_row == 4'd1)
            joy_mask = joy_bits(joy2);
    end

    // Two-stage scan pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            scan_data <= '1;
            scan_row  <= '1;
            keyout    <= '1;
        end else begin
            scan_row  <= row;
            scan_data <= (row < `ATOM_ROWS) ? keys[row] : '1;  // Rows 10-15 read idle
            keyout    <= scan_data & joy_mask;
        end
    end

endmodule

`default_nettype wire

// File: source/atom_keyboard.sv
// Module atom_keyboard, top level joining the scancode decoder and the key matrix
`timescale 1ns/1ps
`default_nettype none

module atom_keyboard
    import atom_kbd_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // PS/2 key event
    input  logic      ps2_strobe,
    input  logic      ps2_pressed,
    input  scancode_t ps2_code,
    // Host scan
    input  row_idx_t  row,
    input  joy_t      joy1,
    input  joy_t      joy2,
    output key_bits_t keyout,
    // Atom control lines, active low
    output logic      shift_out,
    output logic      ctrl_out,
    output logic      repeat_out,
    output logic      break_out,
    output turbo_t    turbo
);

    key_event_if ev_if ();  // Decoder to matrix event path

    scancode_decoder decoder0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_strobe (ps2_strobe),
        .ps2_pressed(ps2_pressed),
        .ps2_code   (ps2_code),
        .ev         (ev_if.decoder),
        .shift_out  (shift_out),
        .ctrl_out   (ctrl_out),
        .repeat_out (repeat_out),
        .break_out  (break_out),
        .turbo      (turbo)
    );

    key_matrix matrix0 (
        .clk   (clk),
        .reset (reset),
        .ev    (ev_if.matrix),
        .row   (row),
        .joy1  (joy1),
        .joy2  (joy2),
        .keyout(keyout)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Module tb_clock_gen generating the free-running testbench clock
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk = 1'b0  // Low from the start, no falling edge at time zero
);

    initial begin
        forever #20 clk = ~clk;  // 40 ns period
    end

endmodule

`default_nettype wire

// File: sim/atom_keyboard_tb.sv
// Module atom_keyboard_tb, file-driven testbench for the Atom keyboard mapper
`timescale 1ns/1ps
`default_nettype none

module atom_keyboard_tb
    import atom_kbd_pkg::*;
();

    logic      clk;
    logic      reset;
    logic      ps2_strobe;
    logic      ps2_pressed;
    scancode_t ps2_code;
    row_idx_t  row;
    joy_t      joy1;
    joy_t      joy2;
    key_bits_t keyout;
    logic      shift_out;
    logic      ctrl_out;
    logic      repeat_out;
    logic      break_out;
    turbo_t    turbo;

    int passed;
    int failed;
    int test_errors;  // Failed checks within the current test
    int seed;

    tb_clock_gen clock0 (.clk(clk));

    atom_keyboard dut0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_strobe (ps2_strobe),
        .ps2_pressed(ps2_pressed),
        .ps2_code   (ps2_code),
        .row        (row),
        .joy1       (joy1),
        .joy2       (joy2),
        .keyout     (keyout),
        .shift_out  (shift_out),
        .ctrl_out   (ctrl_out),
        .repeat_out (repeat_out),
        .break_out  (break_out),
        .turbo      (turbo)
    );

    // Counts falling edges, gives up if they arrive late
    task automatic wait_falling(input int n);
        time start;
        int  seen;
        start = $time;
        seen  = 0;
        while (seen < n) begin
            @(negedge clk);
            seen++;
            if ($time - start > time'(n * 40 + 40)) begin
                $display("Timeout while waiting for %0d falling clock edges", n);
                test_errors++;
                seen = n;
            end
        end
    endtask

    task automatic check_bits(input string name, input key_bits_t exp, input key_bits_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_turbo(input string name, input turbo_t exp, input turbo_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    // One-cycle strobe, returns once the matrix bit is written
    task automatic send_key(input logic pressed, input scancode_t code);
        ps2_strobe  = 1'b1;
        ps2_pressed = pressed;
        ps2_code    = code;
        wait_falling(1);
        ps2_strobe = 1'b0;
        wait_falling(1);
    endtask

    task automatic scan_row(input row_idx_t r, output key_bits_t bits);
        row = r;
        wait_falling(2);  // Two-stage scan
        bits = keyout;
    endtask

    function automatic logic select_flag(input int idx);
        case (idx)
            0: return shift_out;
            1: return ctrl_out;
            2: return repeat_out;
            default: return break_out;
        endcase
    endfunction

    // Column order 1, Up, Right, Down, Left, Fire
    function automatic key_bits_t joystick_mask(input joy_t j);
        return {1'b1, j[3], j[0], j[2], j[1], j[4]};
    endfunction

    task automatic run_step(input string name, input string op, input int a,
                            input logic [15:0] b, input int c, input logic [7:0] exp);
        key_bits_t bits;
        joy_t      j1;
        joy_t      j2;
        test_errors = 0;
        if (op == "rows") begin
            for (int r = a; r <= c; r++) begin
                scan_row(row_idx_t'(r), bits);
                check_bits($sformatf("%s row %0d", name, r), exp[5:0], bits);
            end
        end else if (op == "key") begin
            send_key(a[0], b[8:0]);
            scan_row(c[3:0], bits);
            check_bits(name, exp[5:0], bits);
        end else if (op == "mods") begin
            check_turbo({name, " turbo"}, exp[5:4], turbo);
            check_flag({name, " shift"}, exp[3], shift_out);
            check_flag({name, " ctrl"}, exp[2], ctrl_out);
            check_flag({name, " repeat"}, exp[1], repeat_out);
            check_flag({name, " break"}, exp[0], break_out);
        end else if (op == "mod") begin
            send_key(1'b1, b[8:0]);
            check_flag({name, " held"}, exp[1], select_flag(a));
            send_key(1'b0, b[8:0]);
            check_flag({name, " released"}, exp[0], select_flag(a));
        end else if (op == "turbo") begin
            send_key(1'b1, b[8:0]);
            check_turbo({name, " held"}, exp[1:0], turbo);
            send_key(1'b0, b[8:0]);
            check_turbo({name, " released"}, exp[1:0], turbo);  // Setting persists
        end else if (op == "joy") begin
            if (a == 1)
                joy1 = b;
            else
                joy2 = b;
            scan_row(c[3:0], bits);
            check_bits(name, exp[5:0], bits);
        end else if (op == "rjoy") begin
            for (int k = 0; k < a; k++) begin
                j1   = joy_t'($random(seed));
                j2   = joy_t'($random(seed));
                joy1 = j1;
                joy2 = j2;
                scan_row(c[3:0], bits);
                check_bits($sformatf("%s draw %0d", name, k),
                           exp[5:0] & joystick_mask((c == 0) ? j1 : j2), bits);
            end
        end else begin
            $display("Unknown operation %s in test %s", op, name);
            test_errors++;
        end
        if (test_errors == 0) begin
            passed++;
            $display("[PASS] %s", name);
        end else begin
            failed++;
        end
    endtask

    initial begin
        string       line;
        string       name;
        string       op;
        int          fd;
        int          count;
        int          a;
        int          c;
        logic [15:0] b;
        logic [7:0]  exp;
        passed      = 0;
        failed      = 0;
        test_errors = 0;
        seed        = 66;
        reset       = 1'b1;
        ps2_strobe  = 1'b0;
        ps2_pressed = 1'b0;
        ps2_code    = '0;
        row         = '0;
        joy1        = '1;  // Joystick lines idle high
        joy2        = '1;
        wait_falling(4);
        reset = 1'b0;
        fd = $fopen("sim/atom_keyboard_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/atom_keyboard_stimulus.txt");
            failed++;
        end else begin
            while (!$feof(fd)) begin
                count = $fgets(line, fd);
                if (count != 0 && line.len() > 1 && line[0] != "#") begin
                    count = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, exp);
                    if (count != 6) begin
                        $display("Malformed stimulus line: %s", line);
                        failed++;
                    end else begin
                        run_step(name, op, a, b, c, exp);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Tests: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Guards against a stopped clock
    initial begin
        #2ms;
        $display("Timeout: the run did not finish within 2 ms");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/atom_keyboard_stimulus.txt
# Columns: name op a b c expected, numbers in hex. rows: a..c; key: a pressed, b code, c row
# mod: a flag, b code, exp {held,released}; turbo: b code; joy: a stick, b word; rjoy: a draws
reset_rows       rows  0 000 f 3f
reset_mods       mods  0 000 0 0f
press_a          key   1 01c 6 37
a_only_low_rows  rows  0 000 5 3f
a_only_high_rows rows  7 000 f 3f
hold_g           key   1 034 0 37
hold_q_same_row  key   1 015 0 27
a_still_held     rows  6 000 6 37
release_a        key   0 01c 6 3f
release_g        key   0 034 0 2f
release_q        key   0 015 0 3f
right_e0         key   1 174 3 3e
right_plain_rel  key   0 074 3 3f
right_plain      key   1 074 3 3e
right_e0_rel     key   0 174 3 3f
unmapped         key   1 0ff 0 3f
unmapped_rows    rows  0 000 f 3f
lshift           mod   0 012 0 1
rshift           mod   0 059 0 1
lctrl            mod   1 014 0 1
rctrl            mod   1 114 0 1
lalt_repeat      mod   2 011 0 1
f10_break        mod   3 009 0 1
f2_turbo         turbo 0 006 0 1
f3_turbo         turbo 0 004 0 2
f4_turbo         turbo 0 00c 0 3
f1_turbo         turbo 0 005 0 0
joy1_right       joy   1 fffe 0 37
joy1_up          joy   1 fff7 0 2f
joy1_other_row   joy   1 0000 2 3f
joy1_clear       joy   1 ffff 0 3f
joy2_on_row0     joy   2 0000 0 3f
joy2_right       joy   2 fffe 1 37
joy2_clear       joy   2 ffff 1 3f
hold_g_joy       key   1 034 0 37
hold_z_joy       key   1 01a 1 1f
random_row0      rjoy  8 000 0 37
random_row1      rjoy  8 000 1 1f

// File: files.f
+incdir+source
source/atom_kbd_pkg.sv
source/key_event_if.sv
source/scancode_decoder.sv
source/key_matrix.sv
source/atom_keyboard.sv
sim/tb_clock_gen.sv
sim/atom_keyboard_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the keyboard mapper testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim_run.log

verilator --binary --timing -f files.f --top-module atom_keyboard_tb \
    -Mdir "$BUILD_DIR" -o atom_keyboard_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/atom_keyboard_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0
